// ==== src/mac_cfg_defs.svh ====
`ifndef MAC_CFG_DEFS_SVH
`define MAC_CFG_DEFS_SVH

// clocks the sequencer idles after reset before touching the bus
`define MAC_CFG_STARTUP_CYCLES  8

// cycles the register bank holds waitrequest high on every access
`define MAC_CFG_WAIT_STATES     2

// number of address/data pairs in the initialisation table
`define MAC_CFG_INIT_ENTRIES    3

// register map of the MAC control and status bank
`define MAC_CFG_ADDR_SCRATCH     8'h01
`define MAC_CFG_ADDR_CMD_CONFIG  8'h02
`define MAC_CFG_ADDR_TX_IPG      8'h0e
`define MAC_CFG_ADDR_MDIO_ADDR0  8'h94

`endif

// ==== src/mac_cfg_pkg.sv ====
package mac_cfg_pkg;

    // register address on the memory-mapped bus
    typedef logic [7:0] csr_addr_t;

    // register data word
    typedef logic [31:0] csr_data_t;

    // one step of the initialisation table
    typedef struct packed {
        csr_addr_t addr;
        csr_data_t data;
    } init_entry_t;

    // configuration sequencer states
    typedef enum logic [1:0] {
        startup,   // counting out the start-up delay
        fetch,     // latching the next table entry
        write,     // first cycle of a bus write
        wait_ack   // holding the write until waitrequest drops
    } seq_state_t;

endpackage

// ==== src/mac_init_rom.sv ====
`timescale 1ns/1ps
`include "mac_cfg_defs.svh"

module mac_init_rom import mac_cfg_pkg::*; (
    input  logic [1:0]  index,
    output init_entry_t entry
);

    always_comb begin
        case (index)
            2'd0: begin
                entry.addr = `MAC_CFG_ADDR_CMD_CONFIG;
                entry.data = 32'h0100_0093;  // tx and rx enabled, promiscuous, pad strip
            end
            2'd1: begin
                entry.addr = `MAC_CFG_ADDR_TX_IPG;
                entry.data = 32'h0000_0004;
            end
            2'd2: begin
                entry.addr = `MAC_CFG_ADDR_MDIO_ADDR0;
                entry.data = 32'h0000_0007;  // PHY sits at MDIO address 7
            end
            default: begin
                // the sequencer never issues entries past the end of the table
                entry.addr = `MAC_CFG_ADDR_SCRATCH;
                entry.data = '0;
            end
        endcase
    end

endmodule

// ==== src/mac_cfg_sequencer.sv ====
`timescale 1ns/1ps
`include "mac_cfg_defs.svh"

module mac_cfg_sequencer import mac_cfg_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        waitrequest,
    input  init_entry_t entry,
    output logic [1:0]  index,
    output csr_addr_t   address,
    output logic        write,
    output csr_data_t   writedata,
    output logic        init_done
);

    localparam int cnt_w = $clog2(`MAC_CFG_STARTUP_CYCLES + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`MAC_CFG_STARTUP_CYCLES - 1);
    localparam logic [1:0] index_last = 2'(`MAC_CFG_INIT_ENTRIES - 1);

    seq_state_t       state;
    logic [cnt_w-1:0] count;
    logic             load;
    logic             ack;

    // a new entry is only taken while the table is still being walked
    assign load = (state == fetch) && !init_done;

    // the slave completes the write on the first edge with waitrequest low
    assign ack = write && !waitrequest;

    // start-up delay first, then one fetch and one bus write per table entry
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= startup;
            count     <= '0;
            index     <= 2'd0;
            write     <= 1'b0;
            init_done <= 1'b0;
        end else begin
            case (state)
                startup: begin
                    if (count == cnt_last) begin
                        state <= fetch;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                fetch: begin
                    if (load) begin
                        write <= 1'b1;               // address and data latch on this edge
                        state <= mac_cfg_pkg::write;
                    end
                end
                mac_cfg_pkg::write, wait_ack: begin
                    if (ack) begin
                        write <= 1'b0;
                        index <= index + 2'd1;
                        state <= fetch;              // sits here idle once init_done is set
                        if (index == index_last) begin
                            init_done <= 1'b1;
                        end
                    end else begin
                        state <= wait_ack;           // hold the request under back-pressure
                    end
                end
                default: begin
                    state <= startup;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            address   <= entry.addr;
            writedata <= entry.data;
        end
    end

endmodule

// ==== src/mac_bus_mux.sv ====
`timescale 1ns/1ps

module mac_bus_mux import mac_cfg_pkg::*; (
    input  logic      init_done,

    input  csr_addr_t seq_address,
    input  logic      seq_write,
    input  csr_data_t seq_writedata,
    output logic      seq_waitrequest,

    input  csr_addr_t host_address,
    input  logic      host_read,
    input  logic      host_write,
    input  csr_data_t host_writedata,
    output logic      host_waitrequest,
    output csr_data_t host_readdata,

    input  logic      csr_waitrequest,
    input  csr_data_t csr_readdata,
    output csr_addr_t csr_address,
    output logic      csr_read,
    output logic      csr_write,
    output csr_data_t csr_writedata
);

    // request side toward the register bank
    always_comb begin
        if (init_done) begin
            csr_address   = host_address;
            csr_read      = host_read;
            csr_write     = host_write;
            csr_writedata = host_writedata;
        end else begin
            csr_address   = seq_address;
            csr_read      = 1'b0;               // the sequencer only writes
            csr_write     = seq_write;
            csr_writedata = seq_writedata;
        end
    end

    // response side back to whichever master owns the bus
    always_comb begin
        if (init_done) begin
            seq_waitrequest  = 1'b1;
            host_waitrequest = csr_waitrequest;
            host_readdata    = csr_readdata;
        end else begin
            seq_waitrequest  = csr_waitrequest;
            host_waitrequest = 1'b1;            // host stalls until init finishes
            host_readdata    = '0;
        end
    end

endmodule

// ==== src/mac_csr_bank.sv ====
`timescale 1ns/1ps
`include "mac_cfg_defs.svh"

module mac_csr_bank import mac_cfg_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  csr_addr_t address,
    input  logic      read,
    input  logic      write,
    input  csr_data_t writedata,
    output logic      waitrequest,
    output csr_data_t readdata,
    output csr_data_t cmd_config,
    output csr_data_t tx_ipg,
    output csr_data_t mdio_addr0
);

    localparam int ws_w = $clog2(`MAC_CFG_WAIT_STATES + 2);
    localparam logic [ws_w-1:0] ws_last = ws_w'(`MAC_CFG_WAIT_STATES);

    logic [ws_w-1:0] ws_count;
    logic            access;
    logic            ack;
    csr_data_t       scratch;

    assign access = read || write;

    // the access completes once the wait states have been served
    assign ack         = access && (ws_count == ws_last);
    assign waitrequest = !ack;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ws_count <= '0;
        end else if (!access || ack) begin
            ws_count <= '0;                     // ready for a back-to-back access
        end else begin
            ws_count <= ws_count + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            scratch    <= '0;
            cmd_config <= '0;
            tx_ipg     <= '0;
            mdio_addr0 <= '0;
        end else if (write && ack) begin
            case (address)
                `MAC_CFG_ADDR_SCRATCH:    scratch    <= writedata;
                `MAC_CFG_ADDR_CMD_CONFIG: cmd_config <= writedata;
                `MAC_CFG_ADDR_TX_IPG:     tx_ipg     <= writedata;
                `MAC_CFG_ADDR_MDIO_ADDR0: mdio_addr0 <= writedata;
                default: ;                      // unmapped writes are dropped
            endcase
        end
    end

    // read data only matters in the cycle the master sees waitrequest low
    always_comb begin
        case (address)
            `MAC_CFG_ADDR_SCRATCH:    readdata = scratch;
            `MAC_CFG_ADDR_CMD_CONFIG: readdata = cmd_config;
            `MAC_CFG_ADDR_TX_IPG:     readdata = tx_ipg;
            `MAC_CFG_ADDR_MDIO_ADDR0: readdata = mdio_addr0;
            default:                  readdata = '0;
        endcase
    end

endmodule

// ==== src/mac_cfg_top.sv ====
`timescale 1ns/1ps

module mac_cfg_top import mac_cfg_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  csr_addr_t host_address,
    input  logic      host_read,
    input  logic      host_write,
    input  csr_data_t host_writedata,
    output logic      host_waitrequest,
    output csr_data_t host_readdata,
    output logic      init_done,
    output csr_data_t cmd_config,
    output csr_data_t tx_ipg,
    output csr_data_t mdio_addr0
);

    logic [1:0]  index;
    init_entry_t entry;

    csr_addr_t   seq_address;
    logic        seq_write;
    csr_data_t   seq_writedata;
    logic        seq_waitrequest;

    csr_addr_t   csr_address;
    logic        csr_read;
    logic        csr_write;
    csr_data_t   csr_writedata;
    logic        csr_waitrequest;
    csr_data_t   csr_readdata;

    mac_init_rom u_rom (
        .index (index),
        .entry (entry)
    );

    mac_cfg_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (seq_waitrequest),
        .entry       (entry),
        .index       (index),
        .address     (seq_address),
        .write       (seq_write),
        .writedata   (seq_writedata),
        .init_done   (init_done)
    );

    mac_bus_mux u_mux (
        .init_done        (init_done),
        .seq_address      (seq_address),
        .seq_write        (seq_write),
        .seq_writedata    (seq_writedata),
        .seq_waitrequest  (seq_waitrequest),
        .host_address     (host_address),
        .host_read        (host_read),
        .host_write       (host_write),
        .host_writedata   (host_writedata),
        .host_waitrequest (host_waitrequest),
        .host_readdata    (host_readdata),
        .csr_waitrequest  (csr_waitrequest),
        .csr_readdata     (csr_readdata),
        .csr_address      (csr_address),
        .csr_read         (csr_read),
        .csr_write        (csr_write),
        .csr_writedata    (csr_writedata)
    );

    mac_csr_bank u_bank (
        .clk         (clk),
        .reset       (reset),
        .address     (csr_address),
        .read        (csr_read),
        .write       (csr_write),
        .writedata   (csr_writedata),
        .waitrequest (csr_waitrequest),
        .readdata    (csr_readdata),
        .cmd_config  (cmd_config),
        .tx_ipg      (tx_ipg),
        .mdio_addr0  (mdio_addr0)
    );

endmodule

// ==== dv/mac_cfg_clkgen.sv ====
`timescale 1ns/1ps

module mac_cfg_clkgen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;  // 8 ns period
        end
    end

    initial begin
        reset = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

// ==== dv/mac_cfg_checker.sv ====
`timescale 1ns/1ps
`include "mac_cfg_defs.svh"

module mac_cfg_checker import mac_cfg_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         init_done,
    input  logic         host_read,
    input  logic         host_write,
    input  logic         host_waitrequest,
    input  csr_data_t    host_readdata,
    input  csr_data_t    cmd_config,
    input  csr_data_t    tx_ipg,
    input  csr_data_t    mdio_addr0,
    input  logic [127:0] test_name,
    input  csr_data_t    exp_readdata,
    input  csr_data_t    exp_cmd_config,
    input  csr_data_t    exp_tx_ipg,
    input  csr_data_t    exp_mdio_addr0,
    input  logic         timed_out,
    output int           pass_count,
    output int           fail_count,
    output int           checks_done
);

    localparam int access_cycles = `MAC_CFG_WAIT_STATES + 1;

    logic         busy = 1'b0;
    logic         report_due = 1'b0;
    logic         init_seen = 1'b0;
    logic         timeout_noted = 1'b0;
    int           lat;
    logic [127:0] l_name;
    logic         l_is_read;
    logic         l_timed;
    csr_data_t    l_rdata;
    csr_data_t    l_cmd;
    csr_data_t    l_tx;
    csr_data_t    l_mdio;
    csr_data_t    got_rdata;
    int           got_lat;
    logic         got_init;

    initial begin
        pass_count  = 0;
        fail_count  = 0;
        checks_done = 0;
    end

    // names travel as packed text, so the leading zero bytes are dropped here
    function automatic string name_text(input logic [127:0] v);
        string s;
        byte   c;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            c = v[i*8 +: 8];
            if (c != 0) begin
                s = $sformatf("%s%c", s, c);
            end
        end
        return s;
    endfunction

    task automatic record(input logic ok, input string n);
        if (ok) begin
            pass_count = pass_count + 1;
            $display("PASS %s", n);
        end else begin
            fail_count = fail_count + 1;
        end
        checks_done = checks_done + 1;
    endtask

    // register outputs are compared one edge after the access, once a write has landed
    task automatic report_access();
        string n;
        logic  ok;
        n  = name_text(l_name);
        ok = 1'b0;
        if (!got_init) begin
            $display("ERROR %s: host access completed while init_done was still low", n);
        end else if (l_is_read && got_rdata !== l_rdata) begin
            $display("FAIL %s: readdata expected %h actual %h", n, l_rdata, got_rdata);
        end else if (l_timed && got_lat != access_cycles) begin
            $display("FAIL %s: latency expected %0d actual %0d", n, access_cycles, got_lat);
        end else if (cmd_config !== l_cmd) begin
            $display("FAIL %s: cmd_config expected %h actual %h", n, l_cmd, cmd_config);
        end else if (tx_ipg !== l_tx) begin
            $display("FAIL %s: tx_ipg expected %h actual %h", n, l_tx, tx_ipg);
        end else if (mdio_addr0 !== l_mdio) begin
            $display("FAIL %s: mdio_addr0 expected %h actual %h", n, l_mdio, mdio_addr0);
        end else begin
            ok = 1'b1;
        end
        record(ok, n);
    endtask

    task automatic check_init();
        logic ok;
        ok = 1'b0;
        if (cmd_config !== exp_cmd_config) begin
            $display("FAIL init_values: cmd_config expected %h actual %h",
                     exp_cmd_config, cmd_config);
        end else if (tx_ipg !== exp_tx_ipg) begin
            $display("FAIL init_values: tx_ipg expected %h actual %h", exp_tx_ipg, tx_ipg);
        end else if (mdio_addr0 !== exp_mdio_addr0) begin
            $display("FAIL init_values: mdio_addr0 expected %h actual %h",
                     exp_mdio_addr0, mdio_addr0);
        end else begin
            ok = 1'b1;
        end
        record(ok, "init_values");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (report_due) begin
                report_due = 1'b0;
                report_access();
            end
            if (init_done && !init_seen) begin
                init_seen = 1'b1;  // the last table write landed on the edge init_done rose
                check_init();
            end
            if (!busy && (host_read || host_write)) begin
                busy      = 1'b1;
                lat       = 0;
                l_name    = test_name;
                l_is_read = host_read;
                l_timed   = init_done;  // latency is only fixed once init is over
                l_rdata   = exp_readdata;
                l_cmd     = exp_cmd_config;
                l_tx      = exp_tx_ipg;
                l_mdio    = exp_mdio_addr0;
            end
            if (busy) begin
                lat = lat + 1;
                if (!host_waitrequest) begin
                    busy       = 1'b0;
                    got_rdata  = host_readdata;
                    got_lat    = lat;
                    got_init   = init_done;
                    report_due = 1'b1;
                end
            end
            if (timed_out && !timeout_noted) begin
                timeout_noted = 1'b1;
                fail_count    = fail_count + 1;
                if (!init_seen) begin
                    $display("ERROR: init_done never rose before the cycle limit");
                end else begin
                    $display("ERROR: host accesses did not finish before the cycle limit");
                end
            end
        end
    end

endmodule

// ==== dv/mac_cfg_tb.sv ====
`timescale 1ns/1ps
`include "mac_cfg_defs.svh"

module mac_cfg_tb import mac_cfg_pkg::*; ();

    localparam int num_tests = 11;
    localparam int max_gap = 3;
    localparam int step_cycles = `MAC_CFG_WAIT_STATES + 2;
    localparam int timeout_cycles = `MAC_CFG_STARTUP_CYCLES + 3 * step_cycles
                                  + num_tests * (step_cycles + max_gap) + 50;

    logic         clk;
    logic         reset;
    csr_addr_t    host_address;
    logic         host_read;
    logic         host_write;
    csr_data_t    host_writedata;
    logic         host_waitrequest;
    csr_data_t    host_readdata;
    logic         init_done;
    csr_data_t    cmd_config;
    csr_data_t    tx_ipg;
    csr_data_t    mdio_addr0;

    logic [127:0] test_name;
    csr_data_t    exp_readdata;
    csr_data_t    exp_cmd_config;
    csr_data_t    exp_tx_ipg;
    csr_data_t    exp_mdio_addr0;
    logic         timed_out = 1'b0;
    int           cycle_count = 0;
    int           pass_count;
    int           fail_count;
    int           checks_done;

    // the stimulus table holds one row per host access
    logic [127:0] t_name [num_tests];
    logic         t_write [num_tests];
    csr_addr_t    t_addr [num_tests];
    csr_data_t    t_wdata [num_tests];
    csr_data_t    t_rdata [num_tests];
    int           n_added = 0;

    // expected register outputs as the register map defines them
    csr_data_t    m_cmd;
    csr_data_t    m_tx;
    csr_data_t    m_mdio;

    mac_cfg_clkgen u_clkgen (
        .clk   (clk),
        .reset (reset)
    );

    mac_cfg_top DUT (
        .clk              (clk),
        .reset            (reset),
        .host_address     (host_address),
        .host_read        (host_read),
        .host_write       (host_write),
        .host_writedata   (host_writedata),
        .host_waitrequest (host_waitrequest),
        .host_readdata    (host_readdata),
        .init_done        (init_done),
        .cmd_config       (cmd_config),
        .tx_ipg           (tx_ipg),
        .mdio_addr0       (mdio_addr0)
    );

    mac_cfg_checker u_checker (
        .clk              (clk),
        .reset            (reset),
        .init_done        (init_done),
        .host_read        (host_read),
        .host_write       (host_write),
        .host_waitrequest (host_waitrequest),
        .host_readdata    (host_readdata),
        .cmd_config       (cmd_config),
        .tx_ipg           (tx_ipg),
        .mdio_addr0       (mdio_addr0),
        .test_name        (test_name),
        .exp_readdata     (exp_readdata),
        .exp_cmd_config   (exp_cmd_config),
        .exp_tx_ipg       (exp_tx_ipg),
        .exp_mdio_addr0   (exp_mdio_addr0),
        .timed_out        (timed_out),
        .pass_count       (pass_count),
        .fail_count       (fail_count),
        .checks_done      (checks_done)
    );

    task automatic add_test(input logic [127:0] name, input logic wr, input csr_addr_t addr,
                            input csr_data_t wdata, input csr_data_t rdata);
        t_name[n_added]  = name;
        t_write[n_added] = wr;
        t_addr[n_added]  = addr;
        t_wdata[n_added] = wdata;
        t_rdata[n_added] = rdata;
        n_added = n_added + 1;
    endtask

    task automatic apply_model(input int i);
        if (t_write[i]) begin
            case (t_addr[i])
                `MAC_CFG_ADDR_CMD_CONFIG: m_cmd  = t_wdata[i];
                `MAC_CFG_ADDR_TX_IPG:     m_tx   = t_wdata[i];
                `MAC_CFG_ADDR_MDIO_ADDR0: m_mdio = t_wdata[i];
                default: ;
            endcase
        end
    endtask

    // holds the request until the edge where waitrequest is seen low
    task automatic run_access(input int i);
        @(posedge clk);
        host_address   <= t_addr[i];
        host_read      <= !t_write[i];
        host_write     <= t_write[i];
        host_writedata <= t_write[i] ? t_wdata[i] : '0;
        test_name      <= t_name[i];
        exp_readdata   <= t_rdata[i];
        exp_cmd_config <= m_cmd;
        exp_tx_ipg     <= m_tx;
        exp_mdio_addr0 <= m_mdio;
        do begin
            @(posedge clk);
        end while (host_waitrequest);
        host_read  <= 1'b0;
        host_write <= 1'b0;
    endtask

    initial begin
        int unsigned seed_ret;
        int unsigned gap;
        csr_data_t   scratch_val;
        host_address   = '0;
        host_read      = 1'b0;
        host_write     = 1'b0;
        host_writedata = '0;
        test_name      = '0;
        exp_readdata   = '0;
        m_cmd          = 32'h0100_0093;
        m_tx           = 32'h0000_0004;
        m_mdio         = 32'h0000_0007;
        exp_cmd_config = m_cmd;
        exp_tx_ipg     = m_tx;
        exp_mdio_addr0 = m_mdio;
        seed_ret       = $urandom(32'h9e18_360b);
        scratch_val    = $urandom;
        add_test("rd_cmd_early", 1'b0, 8'h02, '0, 32'h0100_0093);  // issued before init_done
        add_test("rd_tx_ipg", 1'b0, 8'h0e, '0, 32'h0000_0004);
        add_test("rd_mdio_addr0", 1'b0, 8'h94, '0, 32'h0000_0007);
        add_test("wr_scratch", 1'b1, 8'h01, scratch_val, '0);
        add_test("rd_scratch", 1'b0, 8'h01, '0, scratch_val);
        add_test("wr_tx_ipg", 1'b1, 8'h0e, 32'h0000_000c, '0);
        add_test("rd_tx_ipg_new", 1'b0, 8'h0e, '0, 32'h0000_000c);
        add_test("wr_unmapped", 1'b1, 8'h40, 32'hdead_beef, '0);
        add_test("rd_unmapped", 1'b0, 8'h40, '0, '0);
        add_test("rd_cmd_config", 1'b0, 8'h02, '0, 32'h0100_0093);
        add_test("rd_mdio_final", 1'b0, 8'h94, '0, 32'h0000_0007);
        wait (reset === 1'b1);
        for (int i = 0; i < num_tests; i++) begin
            gap = (i == 0) ? 0 : $urandom % (max_gap + 1);
            repeat (gap) @(posedge clk);
            apply_model(i);
            run_access(i);
        end
        wait (checks_done == num_tests + 1);  // the init check counts as one more
        $display("checks run %0d, passed %0d, failed %0d", checks_done, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // the checker gets one edge to say what hung before the run ends
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            timed_out <= 1'b1;
        end
        if (cycle_count == timeout_cycles + 2) begin
            $display("checks run %0d, passed %0d, failed %0d",
                     checks_done, pass_count, fail_count);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// ==== mac_cfg.f ====
+incdir+src
src/mac_cfg_pkg.sv
src/mac_init_rom.sv
src/mac_cfg_sequencer.sv
src/mac_bus_mux.sv
src/mac_csr_bank.sv
src/mac_cfg_top.sv
dv/mac_cfg_clkgen.sv
dv/mac_cfg_checker.sv
dv/mac_cfg_tb.sv
